// File: source/stepper_macros.svh
// Stepper driver widths, sine table size, PWM width, stall limit and decay option
`ifndef STEPPER_MACROS_SVH
`define STEPPER_MACROS_SVH

// Position count
`define STEP_COUNT_BITS 32 // Signed, wraps

// Electrical angle, 4 quadrants of 64 microsteps
`define PHASE_BITS 8
`define QUARTER_BITS 6 // Index inside one quadrant

// Quarter-wave table, both end points included
`define SINE_ENTRIES 65

// Coil drive
`define AMP_BITS 8 // Table entry and coil amplitude
`define CURRENT_BITS 4 // Current scale, 16 is full range

// PWM carrier, period is 2**PWM_BITS clocks
`define PWM_BITS 8

// Supervisor
`define STALL_LIMIT 512 // Max encoder to step deviation
`define VREF_OFF_BRAKE 1 // 1 = slow decay while vref is low

`endif

// File: source/stepper_pkg.sv
// Shared types of the stepper driver: widths, bundles and supervisor states
`default_nettype none

`include "stepper_macros.svh"

package stepper_pkg;

  // ------------------------------
  // Plain vector types
  // ------------------------------
  typedef logic signed [`STEP_COUNT_BITS-1:0] step_count_t; // Position in microsteps
  typedef logic [`PHASE_BITS-1:0] phase_t; // One electrical turn
  typedef logic [`AMP_BITS-1:0] amp_t; // Coil current amplitude
  typedef logic [`CURRENT_BITS-1:0] current_t; // Current scale
  typedef logic [7:0] step_inc_t; // Microsteps per step pulse, unsigned
  typedef logic [`PWM_BITS-1:0] pwm_count_t; // Carrier value

  // ------------------------------
  // Bundles
  // ------------------------------
  typedef struct packed {
    logic step;   // Step pulse
    logic dir;    // 1 = count up
    logic enable; // Drive the coils
    logic brake;  // Brake while disabled
  } motion_cmd_t;

  typedef struct packed {
    amp_t amp_a; // Cosine coil
    amp_t amp_b; // Sine coil
  } coil_amp_t;

  typedef struct packed {
    logic phase_a1;
    logic phase_a2;
    logic phase_b1;
    logic phase_b2;
    logic vref_a;
    logic vref_b;
  } bridge_out_t;

  // Supervisor modes
  typedef enum logic [1:0] {
    ST_OFF,
    ST_RUN,
    ST_BRAKE,
    ST_FAULT
  } drive_state_e;

endpackage

`default_nettype wire

// File: source/pwm_timer.sv
// Free-running PWM carrier with a strobe at the start of each period
`timescale 1ns/1ps
`default_nettype none

module pwm_timer import stepper_pkg::*; (
  input  wire logic clk,
  input  wire logic resetn,
  output pwm_count_t carrier,
  output logic       period_start
);

  // ------------------------------
  // Carrier counter
  // ------------------------------
  // Wraps at the top on its own, no terminal compare
  always_ff @(posedge clk) begin
    if (resetn) begin
      carrier <= '0;
    end else begin
      carrier <= carrier + 1'b1;
    end
  end

  // Period strobe
  // High for the single cycle where the carrier sits at 0
  assign period_start = (carrier == '0);

endmodule

`default_nettype wire

// File: source/phase_counter.sv
// Step pulse edge detector and signed microstep position accumulator
`timescale 1ns/1ps
`default_nettype none

module phase_counter import stepper_pkg::*; (
  input  wire logic      clk,
  input  wire logic      resetn,
  input  wire logic      step,
  input  wire logic      dir,
  input  wire step_inc_t microsteps,
  output step_count_t    step_count
);

  logic        step_q;   // Previous step sample
  logic        step_rise;
  step_count_t inc_ext;  // Increment widened to the count

  // ------------------------------
  // Step edge
  // ------------------------------
  assign step_rise = step & ~step_q; // New sample high, old one low

  // Unsigned source, so the cast zero-extends
  assign inc_ext = step_count_t'(microsteps);

  // ------------------------------
  // Position accumulator
  // ------------------------------
  always_ff @(posedge clk) begin
    if (resetn) begin
      step_q     <= 1'b0;
      step_count <= '0;
    end else begin
      step_q <= step;
      if (step_rise) begin
        // Forward adds, reverse subtracts, both wrap
        step_count <= dir ? step_count + inc_ext : step_count - inc_ext;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/microstep_table.sv
// Quarter-wave sine lookup scaled by the current setting, one amplitude per coil
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module microstep_table import stepper_pkg::*; (
  input  wire logic     clk,
  input  wire logic     resetn,
  input  wire phase_t   phase,
  input  wire current_t current,
  output coil_amp_t     amps
);

  // round(255 * sin(pi/2 * i/64)), i = 0..64
  localparam amp_t sine_lut [0:`SINE_ENTRIES-1] = '{
      0,   6,  13,  19,  25,  31,  37,  44,  50,  56,
     62,  68,  74,  80,  86,  92,  98, 103, 109, 115,
    120, 126, 131, 136, 142, 147, 152, 157, 162, 167,
    171, 176, 180, 185, 189, 193, 197, 201, 205, 208,
    212, 215, 219, 222, 225, 228, 231, 233, 236, 238,
    240, 242, 244, 246, 247, 249, 250, 251, 252, 253,
    254, 254, 255, 255, 255
  };
  localparam logic [`QUARTER_BITS:0] quarter_max = `SINE_ENTRIES - 1;

  logic                    odd_quadrant;
  logic [`QUARTER_BITS:0]  idx_fwd; // k
  logic [`QUARTER_BITS:0]  idx_rev; // 64 - k
  amp_t                    entry_a;
  amp_t                    entry_b;
  logic [$bits(amp_t)+$bits(current_t)-1:0] prod_a;
  logic [$bits(amp_t)+$bits(current_t)-1:0] prod_b;

  // ------------------------------
  // Table lookup
  // ------------------------------
  assign odd_quadrant = phase[`PHASE_BITS-2]; // Low bit of the quadrant
  assign idx_fwd      = {1'b0, phase[`QUARTER_BITS-1:0]};
  assign idx_rev      = quarter_max - idx_fwd;

  // B is the sine, A the cosine; odd quadrants swap the indices
  assign entry_b = odd_quadrant ? sine_lut[idx_rev] : sine_lut[idx_fwd];
  assign entry_a = odd_quadrant ? sine_lut[idx_fwd] : sine_lut[idx_rev];

  // Scale by current / 16, truncated
  assign prod_a = entry_a * current;
  assign prod_b = entry_b * current;

  always_ff @(posedge clk) begin
    if (resetn) begin
      amps <= '0;
    end else begin
      amps.amp_a <= amp_t'(prod_a >> $bits(current_t));
      amps.amp_b <= amp_t'(prod_b >> $bits(current_t));
    end
  end

endmodule

`default_nettype wire

// File: source/space_vector_modulator.sv
// Per-period amplitude shadow registers and carrier compare for both vref outputs
`timescale 1ns/1ps
`default_nettype none

module space_vector_modulator import stepper_pkg::*; (
  input  wire logic       clk,
  input  wire logic       resetn,
  input  wire coil_amp_t  amps,
  input  wire pwm_count_t carrier,
  input  wire logic       period_start,
  output logic            vref_a,
  output logic            vref_b
);

  coil_amp_t amps_q; // Amplitudes in force for this period

  // ------------------------------
  // Shadow registers
  // ------------------------------
  // Loaded only on the period strobe, so a duty cycle never
  // changes part way through a carrier sweep
  always_ff @(posedge clk) begin
    if (resetn) begin
      amps_q <= '0; // vref low until the first period
    end else if (period_start) begin
      amps_q <= amps;
    end
  end

  // ------------------------------
  // Comparators
  // ------------------------------
  // Edge-aligned, high for the first amp_x counts of each period
  assign vref_a = (carrier < amps_q.amp_a);
  assign vref_b = (carrier < amps_q.amp_b);

endmodule

`default_nettype wire

// File: source/bridge_supervisor.sv
// Bridge supervisor FSM: off, run, brake and latched stall fault
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module bridge_supervisor import stepper_pkg::*; (
  input  wire logic        clk,
  input  wire logic        resetn,
  input  wire logic        enable,
  input  wire logic        brake,
  input  wire step_count_t step_count,
  input  wire step_count_t encoder_count,
  output logic             drive_en,
  output logic             brake_req,
  output logic             faultn
);

  drive_state_e state;
  drive_state_e state_next;

  // ------------------------------
  // Encoder deviation
  // ------------------------------
  // One extra bit so the difference never overflows
  logic signed [`STEP_COUNT_BITS:0] deviation;
  logic [`STEP_COUNT_BITS:0]        deviation_abs;
  logic                             stalled;

  assign deviation     = encoder_count - step_count; // Operands sign-extended first
  assign deviation_abs = deviation[`STEP_COUNT_BITS] ? -deviation : deviation;
  assign stalled       = deviation_abs > `STALL_LIMIT;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_next = state;
    if (!enable) begin
      state_next = brake ? ST_BRAKE : ST_OFF; // Also the only way out of a fault
    end else if (state == ST_FAULT) begin
      state_next = ST_FAULT; // Latched while enabled
    end else if (state == ST_RUN && stalled) begin
      state_next = ST_FAULT;
    end else begin
      state_next = ST_RUN;
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      state <= ST_OFF;
    end else begin
      state <= state_next;
    end
  end

  // Mode outputs, decoded from the state only
  assign drive_en  = (state == ST_RUN);
  assign brake_req = (state == ST_BRAKE);
  assign faultn    = (state != ST_FAULT); // Active low

endmodule

`default_nettype wire

// File: source/dual_hbridge.sv
// Dual H-bridge stepper driver top: step count, sine microstepping, PWM and stall guard
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module dual_hbridge import stepper_pkg::*; (
  input  wire logic        clk,
  input  wire logic        resetn,
  input  wire motion_cmd_t cmd,
  input  wire step_inc_t   microsteps,
  input  wire current_t    current,
  input  wire step_count_t encoder_count,
  output bridge_out_t      bridge,
  output step_count_t      step_count,
  output logic             faultn
);

  localparam bit vref_off_brake_en = (`VREF_OFF_BRAKE != 0);

  phase_t     phase;        // Electrical angle
  logic [1:0] quadrant;
  logic [1:0] polarity;     // {b, a}
  coil_amp_t  amps;
  pwm_count_t carrier;
  logic       period_start;
  logic       vref_a;
  logic       vref_b;
  logic       drive_en;
  logic       brake_req;
  logic       brake_a;      // Pin level while coil A is not driven
  logic       brake_b;

  // ------------------------------
  // Position and angle
  // ------------------------------
  phase_counter u_phase_counter (
    .clk        (clk),
    .resetn     (resetn),
    .step       (cmd.step),
    .dir        (cmd.dir),
    .microsteps (microsteps),
    .step_count (step_count)
  );

  assign phase    = step_count[`PHASE_BITS-1:0];
  assign quadrant = phase[`PHASE_BITS-1 -: 2];

  microstep_table u_microstep_table (
    .clk     (clk),
    .resetn  (resetn),
    .phase   (phase),
    .current (current),
    .amps    (amps)
  );

  // ------------------------------
  // PWM
  // ------------------------------
  pwm_timer u_pwm_timer (
    .clk          (clk),
    .resetn       (resetn),
    .carrier      (carrier),
    .period_start (period_start)
  );

  space_vector_modulator u_space_vector_modulator (
    .clk          (clk),
    .resetn       (resetn),
    .amps         (amps),
    .carrier      (carrier),
    .period_start (period_start),
    .vref_a       (vref_a),
    .vref_b       (vref_b)
  );

  bridge_supervisor u_bridge_supervisor (
    .clk           (clk),
    .resetn        (resetn),
    .enable        (cmd.enable),
    .brake         (cmd.brake),
    .step_count    (step_count),
    .encoder_count (encoder_count),
    .drive_en      (drive_en),
    .brake_req     (brake_req),
    .faultn        (faultn)
  );

  // ------------------------------
  // Polarity and decay
  // ------------------------------
  always_comb begin
    case (quadrant) // Gray sequence, one coil flips per quadrant
      2'd0:    polarity = 2'b11;
      2'd1:    polarity = 2'b01;
      2'd2:    polarity = 2'b00;
      default: polarity = 2'b10;
    endcase
  end

  // Slow decay while vref is off, if enabled
  assign brake_a = brake_req | (vref_off_brake_en & ~vref_a);
  assign brake_b = brake_req | (vref_off_brake_en & ~vref_b);

  always_comb begin
    bridge.vref_a   = vref_a;
    bridge.vref_b   = vref_b;
    bridge.phase_a1 = (drive_en & vref_a) ?  polarity[0] : brake_a;
    bridge.phase_a2 = (drive_en & vref_a) ? ~polarity[0] : brake_a;
    bridge.phase_b1 = (drive_en & vref_b) ?  polarity[1] : brake_b;
    bridge.phase_b2 = (drive_en & vref_b) ? ~polarity[1] : brake_b;
  end

endmodule

`default_nettype wire

// File: testbench/tb_dual_hbridge.sv
// Table-driven testbench with a reference model for the dual H-bridge stepper driver
`timescale 1ns/1ps
`default_nettype none

`include "stepper_macros.svh"

module tb_dual_hbridge import stepper_pkg::*; ();

  localparam int NUM_ROWS       = 14;
  localparam int RESET_CYCLES   = 16;
  localparam int PWM_PERIOD     = 1 << `PWM_BITS;
  localparam int SETTLE_CYCLES  = PWM_PERIOD + 4; // Table latency plus one shadow load
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 2000;
  localparam int QUARTER_STEPS  = `SINE_ENTRIES - 1;
  localparam real PI            = 3.14159265358979;

  // One stimulus row
  typedef struct packed {
    logic               dir;
    step_inc_t          inc;
    current_t           cur;
    logic [7:0]         pulses;
    logic signed [15:0] offset;    // Encoder minus expected count
    logic               enable;
    logic               brake;
    logic               lfsr_fill; // Replace dir, inc, cur, pulses from the LFSR
  } row_t;

  logic         clk = 1'b0;
  logic         resetn;
  motion_cmd_t  cmd;
  step_inc_t    microsteps;
  current_t     current;
  step_count_t  encoder_count;
  bridge_out_t  bridge;
  step_count_t  step_count;
  logic         faultn;

  row_t         rows [NUM_ROWS];
  row_t         cur_row;
  step_count_t  ref_count;   // Model position
  logic         fault_exp;   // Model of the latched stall fault
  pwm_count_t   carrier_ref; // Model of the PWM carrier
  logic [31:0]  lfsr_state;
  int           cycle_count = 0;

  dual_hbridge u_dual_hbridge (
    .clk           (clk),
    .resetn        (resetn),
    .cmd           (cmd),
    .microsteps    (microsteps),
    .current       (current),
    .encoder_count (encoder_count),
    .bridge        (bridge),
    .step_count    (step_count),
    .faultn        (faultn)
  );

  always #4 clk = ~clk; // 8 ns period

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  // Carrier counts 0 to 255 without a stop and starts from 0 after reset
  always @(posedge clk) begin
    if (resetn) begin
      carrier_ref <= '0;
    end else begin
      carrier_ref <= carrier_ref + 1'b1;
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int sine_entry(input int i);
    real angle;
    angle = PI / 2.0 * real'(i) / real'(QUARTER_STEPS);
    return $rtoi(255.0 * $sin(angle) + 0.5); // Rounded
  endfunction

  function automatic coil_amp_t expected_amps(input step_count_t cnt, input current_t cur);
    phase_t    ph;
    int        k;
    int        ent_a;
    int        ent_b;
    coil_amp_t res;
    ph = cnt[`PHASE_BITS-1:0];
    k  = int'(ph[`QUARTER_BITS-1:0]);
    if (ph[`PHASE_BITS-2]) begin // Odd quadrant swaps the entries
      ent_a = sine_entry(k);
      ent_b = sine_entry(QUARTER_STEPS - k);
    end else begin
      ent_a = sine_entry(QUARTER_STEPS - k);
      ent_b = sine_entry(k);
    end
    res.amp_a = amp_t'(ent_a * int'(cur) / 16); // Truncated scale
    res.amp_b = amp_t'(ent_b * int'(cur) / 16);
    return res;
  endfunction

  // Quadrant to {b, a} polarity
  function automatic logic [1:0] quadrant_polarity(input logic [1:0] q);
    case (q)
      2'd0:    return 2'b11;
      2'd1:    return 2'b01;
      2'd2:    return 2'b00;
      default: return 2'b10;
    endcase
  endfunction

  // Expected pins for the modeled vref levels
  function automatic bridge_out_t expected_bridge(input logic va, input logic vb,
                                                  input logic drive, input logic brk,
                                                  input logic [1:0] pol);
    logic        decay;
    logic        lvl_a;
    logic        lvl_b;
    bridge_out_t res;
    decay        = (`VREF_OFF_BRAKE != 0);
    lvl_a        = brk | (decay & ~va);
    lvl_b        = brk | (decay & ~vb);
    res.vref_a   = va;
    res.vref_b   = vb;
    res.phase_a1 = (drive & va) ?  pol[0] : lvl_a;
    res.phase_a2 = (drive & va) ? ~pol[0] : lvl_a;
    res.phase_b1 = (drive & vb) ?  pol[1] : lvl_b;
    res.phase_b2 = (drive & vb) ? ~pol[1] : lvl_b;
    return res;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // One step per bit
      val        = {val[30:0], lfsr_state[0]};
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_count(input string name, input step_count_t got, input step_count_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_amp(input string name, input amp_t got, input amp_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_bridge(input string name, input bridge_out_t got, input bridge_out_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%b expected=%b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_fault(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%b expected=%b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic fill_table();
    // dir, inc, cur, pulses, offset, enable, brake, lfsr_fill
    rows[0]  = '{1'b1, 8'd1,   4'd15, 8'd10, 16'sd0,    1'b1, 1'b0, 1'b0}; // Quadrant 0
    rows[1]  = '{1'b1, 8'd16,  4'd15, 8'd5,  16'sd0,    1'b1, 1'b0, 1'b0}; // Quadrant 1
    rows[2]  = '{1'b1, 8'd32,  4'd8,  8'd2,  16'sd0,    1'b1, 1'b0, 1'b0}; // Quadrant 2
    rows[3]  = '{1'b1, 8'd64,  4'd12, 8'd1,  16'sd0,    1'b1, 1'b0, 1'b0}; // Quadrant 3
    rows[4]  = '{1'b0, 8'd100, 4'd10, 8'd3,  -16'sd512, 1'b1, 1'b0, 1'b0}; // Below zero at the limit
    rows[5]  = '{1'b0, 8'd8,   4'd15, 8'd4,  16'sd0,    1'b0, 1'b1, 1'b0}; // Brake
    rows[6]  = '{1'b1, 8'd5,   4'd9,  8'd3,  16'sd0,    1'b0, 1'b0, 1'b0}; // Off with decay
    rows[7]  = '{1'b1, 8'd2,   4'd6,  8'd2,  16'sd600,  1'b1, 1'b0, 1'b0}; // Stall
    rows[8]  = '{1'b1, 8'd3,   4'd14, 8'd2,  16'sd0,    1'b1, 1'b0, 1'b0}; // Still latched
    rows[9]  = '{1'b0, 8'd40,  4'd11, 8'd2,  16'sd600,  1'b0, 1'b0, 1'b0}; // Cleared
    rows[10] = '{1'b1, 8'd7,   4'd13, 8'd6,  -16'sd300, 1'b1, 1'b0, 1'b0}; // Within limit
    rows[11] = '{1'b0, 8'd0,   4'd0,  8'd0,  16'sd0,    1'b1, 1'b0, 1'b1};
    rows[12] = '{1'b0, 8'd0,   4'd0,  8'd0,  -16'sd700, 1'b1, 1'b0, 1'b1}; // Stall in reverse
    rows[13] = '{1'b0, 8'd0,   4'd0,  8'd0,  16'sd0,    1'b0, 1'b1, 1'b1};
  endtask

  task automatic randomize_fields(inout row_t r);
    logic [31:0] val;
    take_bits(1, val);
    r.dir = val[0];
    take_bits(8, val);
    r.inc = val[7:0];
    take_bits(4, val);
    r.cur = val[3:0];
    take_bits(5, val);
    r.pulses = val[7:0] + 8'd1; // 1 to 32 pulses
  endtask

  // One pulse of 2 cycles high and 2 low
  task automatic step_pulse(input row_t r, input int off);
    cmd.step = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    cmd.step  = 1'b0;
    ref_count = r.dir ? ref_count + step_count_t'(r.inc) : ref_count - step_count_t'(r.inc);
    encoder_count = ref_count + step_count_t'(off); // Encoder follows the motor
    repeat (2) @(posedge clk);
    #1;
  endtask

  // Duty and pin check over one full carrier period
  task automatic measure_period(input coil_amp_t amps_exp, output int duty_a,
                                output int duty_b);
    logic        drive;
    logic        brk;
    logic [1:0]  pol;
    logic        va;
    logic        vb;
    bridge_out_t exp;
    drive  = cur_row.enable & ~fault_exp;
    brk    = ~cur_row.enable & cur_row.brake;
    pol    = quadrant_polarity(ref_count[`PHASE_BITS-1 -: 2]);
    duty_a = 0;
    duty_b = 0;
    for (int c = 0; c < PWM_PERIOD; c++) begin
      @(negedge clk); // Sample mid-cycle
      if (bridge.vref_a) duty_a++;
      if (bridge.vref_b) duty_b++;
      va  = (carrier_ref < amps_exp.amp_a); // High while the carrier is below the amplitude
      vb  = (carrier_ref < amps_exp.amp_b);
      exp = expected_bridge(va, vb, drive, brk, pol);
      check_bridge("bridge", bridge, exp);
    end
  endtask

  task automatic run_row(input row_t r);
    int        off;
    int        duty_a;
    int        duty_b;
    coil_amp_t amps_exp;
    off = int'(r.offset);
    @(posedge clk);
    #1;
    cmd.enable    = r.enable;
    cmd.brake     = r.brake;
    cmd.dir       = r.dir;
    microsteps    = r.inc;
    current       = r.cur;
    encoder_count = ref_count + step_count_t'(off);
    // Fault latches while enabled and clears when enable drops
    fault_exp = r.enable & (fault_exp | (off > `STALL_LIMIT) | (off < -`STALL_LIMIT));
    for (int p = 0; p < int'(r.pulses); p++) begin
      step_pulse(r, off);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_count("step_count", step_count, ref_count);
    check_fault("faultn", faultn, ~fault_exp);
    repeat (SETTLE_CYCLES) @(posedge clk);
    amps_exp = expected_amps(ref_count, r.cur);
    measure_period(amps_exp, duty_a, duty_b);
    check_amp("duty_a", amp_t'(duty_a), amps_exp.amp_a);
    check_amp("duty_b", amp_t'(duty_b), amps_exp.amp_b);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    resetn        = 1'b1; // Reset is active high
    cmd           = '0;
    microsteps    = '0;
    current       = '0;
    encoder_count = '0;
    ref_count     = '0;
    fault_exp     = 1'b0;
    lfsr_state    = 32'h147e;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    resetn = 1'b0;
    @(negedge clk);
    check_count("step_count", step_count, '0);
    check_fault("faultn", faultn, 1'b1);
    for (int i = 0; i < NUM_ROWS; i++) begin
      cur_row = rows[i];
      if (cur_row.lfsr_fill) randomize_fields(cur_row);
      run_row(cur_row);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/stepper_pkg.sv
source/pwm_timer.sv
source/phase_counter.sv
source/microstep_table.sv
source/space_vector_modulator.sv
source/bridge_supervisor.sv
source/dual_hbridge.sv
testbench/tb_dual_hbridge.sv

// File: Makefile
# Verilator build and run for the dual H-bridge stepper driver

VERILATOR ?= verilator
TOP       ?= tb_dual_hbridge
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
FILELIST  ?= sim.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) source/stepper_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
